// File: src/ice51_consts.svh
`ifndef ICE51_CONSTS_SVH
`define ICE51_CONSTS_SVH

// uart timing
`define ICE51_BAUD_DIV 104 // clocks per bit, minus one

// code memory, filled over the serial line at start-up
`define ICE51_CODE_BYTES 512

// program counter and code address width
`define ICE51_PC_W 9

// r0 to r7
`define ICE51_NUM_REGS 8

`endif

// File: src/uart_pkg.sv
package uart_pkg;

   typedef enum logic [1:0] {
      RX_IDLE  = 2'b00,
      RX_START = 2'b01,
      RX_DATA  = 2'b11,
      RX_STOP  = 2'b10
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE  = 2'b00,
      TX_START = 2'b01,
      TX_SEND  = 2'b10
   } tx_state_e;

endpackage

// File: src/cpu_pkg.sv
package cpu_pkg;

   // 8051 encodings, rn forms at their base code
   typedef enum logic [7:0] {
      OP_NOP         = 8'h00,
      OP_INC_A       = 8'h04,
      OP_DEC_A       = 8'h14,
      OP_ADD_A_I     = 8'h24,
      OP_ADD_A_R     = 8'h28, // low 3 bits pick rn
      OP_ADDC_A_I    = 8'h34,
      OP_ANL_A_I     = 8'h54,
      OP_JZ          = 8'h60,
      OP_XRL_A_I     = 8'h64,
      OP_JNZ         = 8'h70,
      OP_MOV_A_I     = 8'h74,
      OP_SJMP        = 8'h80,
      OP_SUBB_A_I    = 8'h94,
      OP_CLR_C       = 8'hC3,
      OP_SETB_C      = 8'hD3,
      OP_CLR_A       = 8'hE4,
      OP_MOV_A_R     = 8'hE8,
      OP_MOVX_DPTR_A = 8'hF0, // goes out on the uart
      OP_CPL_A       = 8'hF4,
      OP_MOV_R_A     = 8'hF8
   } opcode_e;

   typedef enum logic [1:0] {
      SEQ_FETCH, SEQ_DECODE0, SEQ_DECODE1, SEQ_EXECUTE
   } seq_state_e;

endpackage

// File: src/uart_rx.sv
`timescale 1ns/1ps
`include "ice51_consts.svh"

module uart_rx import uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   output logic       o_valid,
   output logic [7:0] o_data
);

   localparam int CNT_W = $clog2(`ICE51_BAUD_DIV + 1);

   rx_state_e        state;
   logic             rx_meta;
   logic             rx_sync;
   logic [CNT_W-1:0] cnt;
   logic             half_bit;
   logic             full_bit;
   logic [7:0]       shift;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1; // line idles high
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   assign half_bit = (cnt == CNT_W'(`ICE51_BAUD_DIV / 2));
   assign full_bit = (cnt == CNT_W'(`ICE51_BAUD_DIV));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
         shift <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_sync) state <= RX_START;
            end
            RX_START: begin
               if (half_bit) begin
                  cnt   <= '0;
                  shift <= 8'h80; // marker walks down to bit 0
                  state <= rx_sync ? RX_IDLE : RX_DATA; // glitch, not a start bit
               end
            end
            RX_DATA: begin
               if (full_bit) begin
                  cnt   <= '0;
                  shift <= {rx_sync, shift[7:1]}; // lsb first
                  if (shift[0]) state <= RX_STOP; // marker out, 8 bits in
               end
            end
            RX_STOP: begin
               if (full_bit) state <= RX_IDLE;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // byte handed over on the stop bit sample
   assign o_valid = (state == RX_STOP) && full_bit;
   assign o_data  = shift;

   a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_valid |=> !o_valid);

endmodule

// File: src/code_loader.sv
`timescale 1ns/1ps
`include "ice51_consts.svh"

module code_loader (
   input  logic                   i_clk,
   input  logic                   i_nrst,
   input  logic                   i_wr_valid,
   input  logic [7:0]             i_wr_data,
   input  logic [`ICE51_PC_W-1:0] i_raddr,
   output logic [7:0]             o_rdata,
   output logic                   o_load_done
);

   localparam int PC_W = `ICE51_PC_W;

   logic [7:0]      mem [`ICE51_CODE_BYTES];
   logic [PC_W-1:0] wr_addr;
   logic            wr_en;

   assign wr_en = i_wr_valid && !o_load_done; // bytes after the image are dropped

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_addr     <= '0;
         o_load_done <= 1'b0;
      end else if (wr_en) begin
         wr_addr <= wr_addr + 1'b1;
         if (wr_addr == PC_W'(`ICE51_CODE_BYTES - 1)) o_load_done <= 1'b1;
      end
   end

   // write port from the receiver, read port for the core
   always_ff @(posedge i_clk) begin
      if (wr_en) mem[wr_addr] <= i_wr_data;
      o_rdata <= mem[i_raddr]; // one cycle latency
   end

   a_load_frozen: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_load_done |=> o_load_done && $stable(wr_addr));

endmodule

// File: src/ice51_alu.sv
`timescale 1ns/1ps

module ice51_alu import cpu_pkg::*; (
   input  opcode_e    i_op,
   input  logic [7:0] i_acc,
   input  logic [7:0] i_operand,
   input  logic       i_carry,
   output logic [7:0] o_acc,
   output logic       o_carry,
   output logic       o_acc_we,
   output logic       o_carry_we
);

   logic       add_cin;
   logic [8:0] add_sum;
   logic [8:0] sub_diff;

   assign add_cin  = (i_op == OP_ADDC_A_I) && i_carry;
   assign add_sum  = {1'b0, i_acc} + {1'b0, i_operand} + {8'd0, add_cin};
   assign sub_diff = {1'b0, i_acc} - {1'b0, i_operand} - {8'd0, i_carry}; // bit 8 is borrow

   always_comb begin
      o_acc      = i_acc;
      o_carry    = i_carry;
      o_acc_we   = 1'b0;
      o_carry_we = 1'b0;
      case (i_op)
         OP_ADD_A_I, OP_ADD_A_R, OP_ADDC_A_I: begin
            o_acc      = add_sum[7:0];
            o_carry    = add_sum[8];
            o_acc_we   = 1'b1;
            o_carry_we = 1'b1;
         end
         OP_SUBB_A_I: begin
            o_acc      = sub_diff[7:0];
            o_carry    = sub_diff[8];
            o_acc_we   = 1'b1;
            o_carry_we = 1'b1;
         end
         OP_INC_A: begin
            o_acc    = i_acc + 8'd1; // carry untouched
            o_acc_we = 1'b1;
         end
         OP_DEC_A: begin
            o_acc    = i_acc - 8'd1;
            o_acc_we = 1'b1;
         end
         OP_ANL_A_I: begin
            o_acc    = i_acc & i_operand;
            o_acc_we = 1'b1;
         end
         OP_XRL_A_I: begin
            o_acc    = i_acc ^ i_operand;
            o_acc_we = 1'b1;
         end
         OP_MOV_A_I, OP_MOV_A_R: begin
            o_acc    = i_operand;
            o_acc_we = 1'b1;
         end
         OP_CLR_A: begin
            o_acc    = 8'h00;
            o_acc_we = 1'b1;
         end
         OP_CPL_A: begin
            o_acc    = ~i_acc;
            o_acc_we = 1'b1;
         end
         OP_CLR_C: begin
            o_carry    = 1'b0;
            o_carry_we = 1'b1;
         end
         OP_SETB_C: begin
            o_carry    = 1'b1;
            o_carry_we = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

// File: src/ice51_core.sv
`timescale 1ns/1ps
`include "ice51_consts.svh"

module ice51_core import cpu_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_nrst,
   input  logic                   i_load_done,
   output logic [`ICE51_PC_W-1:0] o_code_raddr,
   input  logic [7:0]             i_code_rdata,
   output logic                   o_tx_valid,
   output logic [7:0]             o_tx_data,
   input  logic                   i_tx_ready
);

   localparam int PC_W  = `ICE51_PC_W;
   localparam int REG_W = $clog2(`ICE51_NUM_REGS);

   seq_state_e       state;
   seq_state_e       state_next;
   logic [PC_W-1:0]  pc;
   logic [PC_W-1:0]  pc_inc1;
   logic [PC_W-1:0]  pc_seq;
   logic [PC_W-1:0]  pc_target;
   logic [7:0]       op_raw;
   logic [7:0]       op_byte;
   logic [7:0]       imm;
   opcode_e          op;
   logic             two_byte;
   logic             take_branch;
   logic             exec_done;
   logic [7:0]       regs [`ICE51_NUM_REGS];
   logic [REG_W-1:0] reg_sel;
   logic [7:0]       acc;
   logic             carry;
   logic [7:0]       operand;
   logic [7:0]       alu_acc;
   logic             alu_carry;
   logic             alu_acc_we;
   logic             alu_carry_we;

   //////////////////////////////
   // decode

   assign op_byte = (state == SEQ_DECODE0) ? i_code_rdata : op_raw; // live byte in decode0

   always_comb begin
      casez (op_byte)
         8'b0010_1???: op = OP_ADD_A_R;
         8'b1110_1???: op = OP_MOV_A_R;
         8'b1111_1???: op = OP_MOV_R_A;
         OP_NOP, OP_INC_A, OP_DEC_A, OP_ADD_A_I, OP_ADDC_A_I, OP_ANL_A_I, OP_JZ,
         OP_XRL_A_I, OP_JNZ, OP_MOV_A_I, OP_SJMP, OP_SUBB_A_I, OP_CLR_C, OP_SETB_C,
         OP_CLR_A, OP_MOVX_DPTR_A, OP_CPL_A: op = opcode_e'(op_byte);
         default: op = OP_NOP; // unsupported codes
      endcase
   end

   always_comb begin
      case (op)
         OP_MOV_A_I, OP_ADD_A_I, OP_ADDC_A_I, OP_SUBB_A_I, OP_ANL_A_I, OP_XRL_A_I,
         OP_SJMP, OP_JZ, OP_JNZ: two_byte = 1'b1;
         default: two_byte = 1'b0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (state == SEQ_DECODE0) op_raw <= i_code_rdata;
      if (state == SEQ_DECODE1) imm <= i_code_rdata;
   end

   //////////////////////////////
   // sequencer

   assign o_tx_valid = (state == SEQ_EXECUTE) && (op == OP_MOVX_DPTR_A);
   assign o_tx_data  = acc;
   assign exec_done  = (state == SEQ_EXECUTE) && (!o_tx_valid || i_tx_ready); // movx waits

   always_comb begin
      state_next = state;
      case (state)
         SEQ_FETCH:   if (i_load_done) state_next = SEQ_DECODE0;
         SEQ_DECODE0: state_next = two_byte ? SEQ_DECODE1 : SEQ_EXECUTE;
         SEQ_DECODE1: state_next = SEQ_EXECUTE;
         SEQ_EXECUTE: if (exec_done) state_next = SEQ_FETCH;
         default:     state_next = SEQ_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= SEQ_FETCH;
      else state <= state_next;
   end

   //////////////////////////////
   // program counter

   assign pc_inc1      = pc + 1'b1;
   assign pc_seq       = two_byte ? pc + PC_W'(2) : pc_inc1;
   assign pc_target    = pc_seq + {{(PC_W - 8){imm[7]}}, imm}; // signed rel offset
   assign take_branch  = (op == OP_SJMP) ||
                         ((op == OP_JZ) && (acc == 8'h00)) ||
                         ((op == OP_JNZ) && (acc != 8'h00));
   assign o_code_raddr = (state == SEQ_FETCH) ? pc : pc_inc1; // opcode, then operand

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) pc <= '0;
      else if (exec_done) pc <= take_branch ? pc_target : pc_seq;
   end

   //////////////////////////////
   // registers, acc, carry

   assign reg_sel = op_raw[REG_W-1:0];
   assign operand = two_byte ? imm : regs[reg_sel];

   ice51_alu ice51_alu_i (
      .i_op       (op),
      .i_acc      (acc),
      .i_operand  (operand),
      .i_carry    (carry),
      .o_acc      (alu_acc),
      .o_carry    (alu_carry),
      .o_acc_we   (alu_acc_we),
      .o_carry_we (alu_carry_we)
   );

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
      end else if (exec_done) begin
         if (alu_acc_we) acc <= alu_acc;
         if (alu_carry_we) carry <= alu_carry;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int i = 0; i < `ICE51_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (exec_done && (op == OP_MOV_R_A)) begin
         regs[reg_sel] <= acc;
      end
   end

   a_state_legal: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !$isunknown(state));

   // byte must not change while the transmitter is busy
   a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data));

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps
`include "ice51_consts.svh"

module uart_tx import uart_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_valid,
   input  logic [7:0] i_data,
   output logic       o_ready,
   output logic       o_tx
);

   localparam int CNT_W = $clog2(`ICE51_BAUD_DIV + 1);

   tx_state_e        state;
   logic [CNT_W-1:0] cnt;
   logic [3:0]       bit_cnt;
   logic             full_bit;
   logic             xfer;
   logic [7:0]       shift;

   assign o_ready  = (state == TX_IDLE);
   assign xfer     = i_valid && o_ready;
   assign full_bit = (cnt == CNT_W'(`ICE51_BAUD_DIV));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (xfer) state <= TX_START;
            end
            TX_START: begin
               if (full_bit) begin
                  cnt   <= '0;
                  state <= TX_SEND;
               end
            end
            TX_SEND: begin
               if (full_bit) begin
                  cnt     <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 4'd8) state <= TX_IDLE; // stop bit done
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // ones fill in from the top, giving the stop bit
   always_ff @(posedge i_clk) begin
      if (xfer) shift <= i_data;
      else if ((state == TX_SEND) && full_bit) shift <= {1'b1, shift[7:1]};
   end

   assign o_tx = (state == TX_IDLE)  ? 1'b1 :
                 (state == TX_START) ? 1'b0 :
                                       shift[0];

   // idle is only entered from a high stop bit
   a_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (state == TX_IDLE) |-> $past(o_tx));

endmodule

// File: src/ice51_top.sv
`timescale 1ns/1ps
`include "ice51_consts.svh"

module ice51_top (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);

   logic                   rx_valid;
   logic [7:0]             rx_data;
   logic                   load_done;
   logic [`ICE51_PC_W-1:0] code_raddr;
   logic [7:0]             code_rdata;
   logic                   tx_valid;
   logic [7:0]             tx_data;
   logic                   tx_ready;

   uart_rx uart_rx_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_uart_rx),
      .o_valid (rx_valid),
      .o_data  (rx_data)
   );

   code_loader code_loader_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_wr_valid  (rx_valid),
      .i_wr_data   (rx_data),
      .i_raddr     (code_raddr),
      .o_rdata     (code_rdata),
      .o_load_done (load_done)
   );

   ice51_core ice51_core_i (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_load_done  (load_done),
      .o_code_raddr (code_raddr),
      .i_code_rdata (code_rdata),
      .o_tx_valid   (tx_valid),
      .o_tx_data    (tx_data),
      .i_tx_ready   (tx_ready)
   );

   uart_tx uart_tx_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_valid (tx_valid),
      .i_data  (tx_data),
      .o_ready (tx_ready),
      .o_tx    (o_uart_tx)
   );

endmodule

// File: testbench/tb_ice51.sv
`timescale 1ns/1ps
`include "ice51_consts.svh"

module tb_ice51 import cpu_pkg::*; ();

   localparam int          BIT_CYCLES    = `ICE51_BAUD_DIV + 1;
   localparam int          FRAME_CYCLES  = 10 * BIT_CYCLES;
   localparam int          START_TIMEOUT = 20 * FRAME_CYCLES;
   localparam int          QUIET_CYCLES  = 3 * FRAME_CYCLES;
   localparam int          MODEL_STEPS   = 4096;
   localparam logic [31:0] LFSR_SEED     = 32'h57e9f640;
   localparam logic [31:0] LFSR_TAPS     = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

   typedef logic [7:0] byte_q_t [$];

   logic        clk = 1'b0;
   logic        nrst;
   logic        uart_rx;
   logic        uart_tx;
   logic [7:0]  image [`ICE51_CODE_BYTES];
   byte_q_t     exp_q;
   logic [31:0] lfsr_state;
   int          wr_ptr;
   int          n_expected;
   int          n_checked;
   logic        program_sent; // set once the last stop bit goes out

   always #4 clk = ~clk;

   ice51_top ice51_top_i (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_uart_rx (uart_rx),
      .o_uart_tx (uart_tx)
   );

   //////////////////////////////
   // failure reporting

   task automatic end_with_failure();
      $display("Testbench failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic stop_on_failure(input string what);
      $display("%s", what);
      end_with_failure();
   endtask

   task automatic compare_value(input string test_name, input logic [7:0] expected,
                                input logic [7:0] actual);
      if (actual !== expected) begin
         $display("** Error [%s] expected 8'h%02h, actual 8'h%02h", test_name, expected,
                  actual);
         end_with_failure();
      end
   endtask

   //////////////////////////////
   // program image

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // one lfsr step per bit
   function automatic logic [7:0] next_random(input int nbits);
      logic [7:0] v;
      int         i;
      v = '0;
      for (i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[6:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic emit_byte(input logic [7:0] b);
      image[wr_ptr] = b;
      wr_ptr++;
   endtask

   task automatic emit_imm(input logic [7:0] op, input logic [7:0] imm);
      emit_byte(op);
      emit_byte(imm);
   endtask

   task automatic build_program();
      int a;
      int loop_addr;
      for (a = 0; a < `ICE51_CODE_BYTES; a++) begin
         image[a] = 8'h00;
      end
      wr_ptr = 0;
      // immediate alu ops, each result sent
      emit_imm(OP_MOV_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_imm(OP_ADD_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_imm(OP_ANL_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_imm(OP_XRL_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_CPL_A);
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_INC_A);
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_DEC_A);
      emit_byte(OP_DEC_A);
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(8'hA5); // unsupported code, nop
      emit_byte(OP_CLR_A);
      emit_byte(OP_MOVX_DPTR_A);
      // carry chains
      emit_byte(OP_SETB_C);
      emit_imm(OP_MOV_A_I, next_random(8));
      emit_imm(OP_ADDC_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_CLR_C);
      emit_imm(OP_SUBB_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_SETB_C);
      emit_imm(OP_SUBB_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_imm(OP_MOV_A_I, 8'hFF);
      emit_imm(OP_ADD_A_I, next_random(8) | 8'h01); // always overflows
      emit_imm(OP_ADDC_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      // register bank
      emit_imm(OP_MOV_A_I, next_random(8));
      emit_byte(OP_MOV_R_A | 8'd3);
      emit_imm(OP_MOV_A_I, next_random(8));
      emit_byte(OP_ADD_A_R | 8'd3);
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_MOV_R_A | 8'd5);
      emit_byte(OP_CLR_A);
      emit_byte(OP_MOV_A_R | 8'd5);
      emit_byte(OP_MOVX_DPTR_A);
      // countdown on r2, one send per pass
      emit_imm(OP_MOV_A_I, next_random(3) + 8'd1);
      emit_byte(OP_MOV_R_A | 8'd2);
      loop_addr = wr_ptr;
      emit_byte(OP_MOV_A_R | 8'd2);
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_DEC_A);
      emit_byte(OP_MOV_R_A | 8'd2);
      emit_imm(OP_JNZ, 8'(loop_addr - (wr_ptr + 2)));
      // jz taken, then not taken
      emit_byte(OP_CLR_A);
      emit_imm(OP_JZ, 8'd1);
      emit_byte(OP_MOVX_DPTR_A); // skipped
      emit_imm(OP_MOV_A_I, next_random(8) | 8'h01);
      emit_imm(OP_JZ, 8'd1);
      emit_byte(OP_MOVX_DPTR_A);
      // sjmp over three bytes
      emit_imm(OP_SJMP, 8'd3);
      emit_imm(OP_MOV_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_MOVX_DPTR_A);
      // back to back sends against a busy transmitter
      emit_imm(OP_MOV_A_I, next_random(8));
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_INC_A);
      emit_byte(OP_MOVX_DPTR_A);
      emit_byte(OP_MOVX_DPTR_A);
      emit_imm(OP_SJMP, 8'hFE); // park here
   endtask

   //////////////////////////////
   // reference model

   function automatic byte_q_t model_program();
      byte_q_t    sent;
      logic [8:0] pc;
      logic [8:0] pc_next;
      logic [8:0] target;
      logic [7:0] opc;
      logic [7:0] imm;
      logic [7:0] acc;
      logic [7:0] regs [8];
      logic       carry;
      logic       parked;
      int         sum;
      int         steps;
      int         r;
      pc = '0;
      acc = '0;
      carry = 1'b0;
      parked = 1'b0;
      steps = 0;
      for (r = 0; r < 8; r++) begin
         regs[r] = '0;
      end
      while (!parked && steps < MODEL_STEPS) begin
         opc = image[pc];
         imm = image[pc + 9'd1];
         pc_next = pc + 9'd1;
         target = 9'(int'(pc) + 2 + int'($signed(imm))); // after the offset byte
         steps++;
         if (opc inside {OP_MOV_A_I, OP_ADD_A_I, OP_ADDC_A_I, OP_SUBB_A_I, OP_ANL_A_I,
                         OP_XRL_A_I, OP_SJMP, OP_JZ, OP_JNZ}) begin
            pc_next = pc + 9'd2;
         end
         casez (opc)
            OP_MOV_A_I:     acc = imm;
            OP_ADD_A_I: begin
               sum   = int'(acc) + int'(imm);
               carry = (sum > 255);
               acc   = 8'(sum);
            end
            OP_ADDC_A_I: begin
               sum   = int'(acc) + int'(imm) + int'(carry);
               carry = (sum > 255);
               acc   = 8'(sum);
            end
            OP_SUBB_A_I: begin
               sum   = int'(acc) - int'(imm) - int'(carry);
               carry = (sum < 0); // borrow
               acc   = 8'(sum);
            end
            OP_ANL_A_I:     acc = acc & imm;
            OP_XRL_A_I:     acc = acc ^ imm;
            OP_INC_A:       acc = acc + 8'd1;
            OP_DEC_A:       acc = acc - 8'd1;
            OP_CLR_A:       acc = 8'h00;
            OP_CPL_A:       acc = ~acc;
            OP_CLR_C:       carry = 1'b0;
            OP_SETB_C:      carry = 1'b1;
            8'b0010_1???: begin // add a,rn
               sum   = int'(acc) + int'(regs[opc[2:0]]);
               carry = (sum > 255);
               acc   = 8'(sum);
            end
            8'b1110_1???:   acc = regs[opc[2:0]];
            8'b1111_1???:   regs[opc[2:0]] = acc;
            OP_MOVX_DPTR_A: sent.push_back(acc);
            OP_SJMP: begin
               if (imm == 8'hFE) parked = 1'b1;
               pc_next = target;
            end
            OP_JZ:  if (acc == 8'h00) pc_next = target;
            OP_JNZ: if (acc != 8'h00) pc_next = target;
            default: ;
         endcase
         pc = pc_next;
      end
      return sent;
   endfunction

   //////////////////////////////
   // serial driver and monitor

   // 8n1, one extra idle cycle between frames
   task automatic send_frame(input logic [7:0] data, input logic last);
      int i;
      @(posedge clk);
      #1;
      uart_rx = 1'b0;
      for (i = 0; i < 8; i++) begin
         repeat (BIT_CYCLES) @(posedge clk);
         #1;
         uart_rx = data[i];
      end
      repeat (BIT_CYCLES) @(posedge clk);
      #1;
      uart_rx = 1'b1;
      if (last) program_sent = 1'b1; // core may start inside this stop bit
      repeat (BIT_CYCLES) @(posedge clk);
   endtask

   task automatic wait_frame_start();
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         if (!program_sent && uart_tx !== 1'b1)
            stop_on_failure("serial output left the idle level before the program was loaded");
         if (program_sent) waited++;
         if (waited > START_TIMEOUT)
            stop_on_failure("no frame started on the serial output in time");
      end while (uart_tx !== 1'b0);
   endtask

   // samples near the middle of each bit
   task automatic read_frame(output logic [7:0] data);
      int i;
      repeat (BIT_CYCLES / 2) @(negedge clk);
      if (uart_tx !== 1'b0) stop_on_failure("start bit was not low at its middle");
      for (i = 0; i < 8; i++) begin
         repeat (BIT_CYCLES) @(negedge clk);
         data[i] = uart_tx;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      if (uart_tx !== 1'b1) stop_on_failure("stop bit was not high at its middle");
   endtask

   initial begin : monitor
      logic [7:0] got;
      logic [7:0] want;
      int         waited;
      waited = 0;
      while (nrst !== 1'b1) begin
         @(posedge clk);
         waited++;
         if (waited > 16) stop_on_failure("reset was never released");
      end
      forever begin
         wait_frame_start();
         read_frame(got);
         if (exp_q.size() == 0) begin
            stop_on_failure("a frame arrived when no more bytes were expected");
         end else begin
            want = exp_q.pop_front();
            compare_value($sformatf("movx byte %0d", n_checked), want, got);
            n_checked++;
         end
      end
   end

   //////////////////////////////
   // main sequence

   initial begin : main
      int i;
      int waited;
      nrst = 1'b0;
      uart_rx = 1'b1; // line idle
      program_sent = 1'b0;
      n_checked = 0;
      lfsr_state = LFSR_SEED;
      build_program();
      exp_q = model_program();
      n_expected = exp_q.size();
      repeat (3) @(posedge clk);
      #1;
      nrst = 1'b1;
      repeat (2) @(posedge clk);
      for (i = 0; i < `ICE51_CODE_BYTES; i++) begin
         send_frame(image[i], i == `ICE51_CODE_BYTES - 1);
      end
      waited = 0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
         waited++;
         if (waited > (n_expected + 4) * FRAME_CYCLES)
            stop_on_failure("timed out waiting for the expected bytes on the serial output");
      end
      // core is parked, the line must stay quiet
      waited = 0;
      while (waited < QUIET_CYCLES) begin
         @(negedge clk);
         waited++;
         if (uart_tx !== 1'b1)
            stop_on_failure("serial output sent more frames than the program should");
      end
      $display("Testbench passed");
      $finish;
   end

endmodule

// File: list.f
+incdir+src
src/uart_pkg.sv
src/cpu_pkg.sv
src/uart_rx.sv
src/code_loader.sv
src/ice51_alu.sv
src/ice51_core.sv
src/uart_tx.sv
src/ice51_top.sv
testbench/tb_ice51.sv

// File: Bender.yml
package:
  name: ice51

sources:
  - include_dirs:
      - src
    files:
      - src/uart_pkg.sv
      - src/cpu_pkg.sv
      - src/uart_rx.sv
      - src/code_loader.sv
      - src/ice51_alu.sv
      - src/ice51_core.sv
      - src/uart_tx.sv
      - src/ice51_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_ice51.sv
